//--- Makefile
VERILATOR = verilator
FLAGS     = --assert --timing
TOP       = decode_stage_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/decode_control.sv
rtl/imm_gen.sv
rtl/hazard_unit.sv
rtl/branch_unit.sv
rtl/decode_stage.sv
testbench/decode_stage_tb.sv

//--- rtl/branch_unit.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module branch_unit (
  input  decode_pkg::if_id_t   if_id,
  input  decode_pkg::ctrl_t    ctrl,
  input  logic [`XLEN-1:0]     imm,
  input  decode_pkg::fwd_sel_e sel1,
  input  decode_pkg::fwd_sel_e sel2,
  input  logic [`XLEN-1:0]     ex_mem_result,
  input  logic [`XLEN-1:0]     mem_wb_result,
  input  logic                 block,
  output logic                 taken,
  output logic [`PC_W-1:0]     target
);

  logic [`XLEN-1:0] op1, op2;
  logic [`XLEN-1:0] jalr_sum;
  logic [2:0]       funct3;
  logic             cond;
  logic             raw_taken;

  function automatic logic [`XLEN-1:0] fwd_mux(input decode_pkg::fwd_sel_e sel,
                                               input logic [`XLEN-1:0] reg_val,
                                               input logic [`XLEN-1:0] exm_val,
                                               input logic [`XLEN-1:0] mwb_val);
    logic [`XLEN-1:0] val;
    case (sel)
      decode_pkg::FWD_EX_MEM: val = exm_val;
      decode_pkg::FWD_MEM_WB: val = mwb_val;
      default: val = reg_val;
    endcase
    return val;
  endfunction

  assign op1    = fwd_mux(sel1, if_id.rs1_data, ex_mem_result, mem_wb_result);
  assign op2    = fwd_mux(sel2, if_id.rs2_data, ex_mem_result, mem_wb_result);
  assign funct3 = if_id.instr[14:12];

  //////////////////////////////
  // Condition and decision
  //////////////////////////////

  always_comb begin
    case (funct3)
      3'b000: cond = (op1 == op2);
      3'b001: cond = (op1 != op2);
      3'b100: cond = ($signed(op1) < $signed(op2));
      3'b101: cond = ($signed(op1) >= $signed(op2));
      3'b110: cond = (op1 < op2);
      3'b111: cond = (op1 >= op2);
      default: cond = 1'b0;
    endcase
  end

  assign raw_taken = ctrl.jal || ctrl.jalr || (ctrl.branch && cond);
  assign taken     = raw_taken && !block;

  // jalr clears bit 0 of the sum; others are pc relative
  assign jalr_sum = op1 + imm;
  assign target   = ctrl.jalr ? {jalr_sum[`PC_W-1:1], 1'b0} : if_id.pc + imm[`PC_W-1:0];

  // A taken decision comes from exactly one control-flow kind
  always_comb begin
    assert (!taken || $onehot({ctrl.branch, ctrl.jal, ctrl.jalr}))
      else $error("branch_unit: taken with mixed control");
  end

endmodule

//--- rtl/decode_consts.svh
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// Register and immediate width, fixed by RV32I
`define XLEN 32

// Program counter width seen by the stage
`define PC_W 16

// Register file address width
`define REG_W 5

// Exact ECALL instruction word
`define ECALL_WORD 32'h0000_0073

`endif

//--- rtl/decode_control.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module decode_control (
  input  logic [`XLEN-1:0] instr,
  output decode_pkg::ctrl_t ctrl
);

  decode_pkg::opcode_e opcode;
  logic [2:0]          funct3;
  logic                funct7_b5;

  // ALU function for OP and OP_IMM; SUB exists only in register form
  function automatic decode_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt,
                                                  input logic is_reg);
    decode_pkg::alu_op_e op;
    case (f3)
      3'd0: begin
        if (alt && is_reg) op = decode_pkg::SUB;
        else op = decode_pkg::ADD;
      end
      3'd1: op = decode_pkg::SLL;
      3'd2: op = decode_pkg::SLT;
      3'd3: op = decode_pkg::SLTU;
      3'd4: op = decode_pkg::XOR;
      3'd5: begin
        if (alt) op = decode_pkg::SRA;
        else op = decode_pkg::SRL;
      end
      3'd6: op = decode_pkg::OR;
      default: op = decode_pkg::AND;
    endcase
    return op;
  endfunction

  assign opcode    = decode_pkg::opcode_e'(instr[6:0]);
  assign funct3    = instr[14:12];
  assign funct7_b5 = instr[30];

  always_comb begin
    ctrl = '0;
    case (opcode)
      decode_pkg::LUI: begin
        ctrl.alu_op    = decode_pkg::PASS_B;
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.lui       = 1'b1;
        ctrl.imm_fmt   = decode_pkg::IMM_U;
      end
      decode_pkg::AUIPC: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.auipc     = 1'b1;
        ctrl.imm_fmt   = decode_pkg::IMM_U;
      end
      decode_pkg::JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.jal       = 1'b1;
        ctrl.imm_fmt   = decode_pkg::IMM_J;
      end
      decode_pkg::JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.jalr      = 1'b1;
        ctrl.uses_rs1  = 1'b1;
        ctrl.imm_fmt   = decode_pkg::IMM_I;
      end
      decode_pkg::BRANCH: begin
        ctrl.branch   = 1'b1;
        ctrl.uses_rs1 = 1'b1;
        ctrl.uses_rs2 = 1'b1;
        ctrl.imm_fmt  = decode_pkg::IMM_B;
      end
      decode_pkg::LOAD: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.mem_size  = funct3;
        ctrl.uses_rs1  = 1'b1;
        ctrl.imm_fmt   = decode_pkg::IMM_I;
      end
      decode_pkg::STORE: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
        ctrl.mem_size  = funct3;
        ctrl.uses_rs1  = 1'b1;
        ctrl.uses_rs2  = 1'b1;
        ctrl.imm_fmt   = decode_pkg::IMM_S;
      end
      decode_pkg::OP_IMM: begin
        ctrl.alu_op    = alu_sel(funct3, funct7_b5, 1'b0);
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.uses_rs1  = 1'b1;
        ctrl.imm_fmt   = decode_pkg::IMM_I;
      end
      decode_pkg::OP: begin
        ctrl.alu_op    = alu_sel(funct3, funct7_b5, 1'b1);
        ctrl.reg_write = 1'b1;
        ctrl.uses_rs1  = 1'b1;
        ctrl.uses_rs2  = 1'b1;
      end
      // Only the exact ECALL word is recognised
      decode_pkg::SYSTEM: ctrl.ecall = (instr == `ECALL_WORD);
      default: ctrl = '0;
    endcase
  end

endmodule

//--- rtl/decode_pkg.sv
`include "decode_consts.svh"

package decode_pkg;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // RV32I major opcodes
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ADD    = 4'd0,
    SUB    = 4'd1,
    SLL    = 4'd2,
    SLT    = 4'd3,
    SLTU   = 4'd4,
    XOR    = 4'd5,
    SRL    = 4'd6,
    SRA    = 4'd7,
    OR     = 4'd8,
    AND    = 4'd9,
    PASS_B = 4'd10
  } alu_op_e;

  // Zero code means no immediate, so an all-zero control is a bubble
  typedef enum logic [2:0] {
    IMM_NONE = 3'd0,
    IMM_I    = 3'd1,
    IMM_S    = 3'd2,
    IMM_B    = 3'd3,
    IMM_U    = 3'd4,
    IMM_J    = 3'd5
  } imm_fmt_e;

  typedef enum logic [1:0] {
    FWD_REG    = 2'd0,
    FWD_EX_MEM = 2'd1,
    FWD_MEM_WB = 2'd2
  } fwd_sel_e;

  //////////////////////////////
  // Stage boundaries
  //////////////////////////////

  typedef struct packed {
    alu_op_e    alu_op;
    logic       alu_src;
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    logic [2:0] mem_size;
    logic       branch;
    logic       jal;
    logic       jalr;
    logic       auipc;
    logic       lui;
    logic       ecall;
    logic       uses_rs1;
    logic       uses_rs2;
    imm_fmt_e   imm_fmt;
  } ctrl_t;

  typedef struct packed {
    logic [`XLEN-1:0] instr;
    logic [`PC_W-1:0] pc;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic             valid;
  } if_id_t;

  typedef struct packed {
    logic              reg_write;
    logic              mem_read;
    logic [`REG_W-1:0] rd;
    logic [`XLEN-1:0]  result;
  } ex_mem_fwd_t;

  typedef struct packed {
    logic              reg_write;
    logic [`REG_W-1:0] rd;
    logic [`XLEN-1:0]  result;
  } mem_wb_fwd_t;

  typedef struct packed {
    ctrl_t             ctrl;
    logic [`REG_W-1:0] rs1;
    logic [`REG_W-1:0] rs2;
    logic [`REG_W-1:0] rd;
    logic [`XLEN-1:0]  rs1_data;
    logic [`XLEN-1:0]  rs2_data;
    logic [`XLEN-1:0]  imm;
    logic [`PC_W-1:0]  pc;
    logic              valid;
  } id_ex_t;

endpackage

//--- rtl/decode_stage.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module decode_stage (
  input  logic                    bus,
  input  logic                    rst_n,
  input  logic                    hold,
  input  decode_pkg::if_id_t      if_id,
  input  decode_pkg::ex_mem_fwd_t ex_mem,
  input  decode_pkg::mem_wb_fwd_t mem_wb,
  output decode_pkg::id_ex_t      id_ex,
  output logic                    stall,
  output logic                    branch_taken,
  output logic [`PC_W-1:0]        branch_target
);

  decode_pkg::ctrl_t    ctrl;
  decode_pkg::fwd_sel_e sel1, sel2;
  logic [`XLEN-1:0]     imm;
  logic [`REG_W-1:0]    rs1, rs2, rd;
  logic                 hz_stall;
  logic                 flush_q;
  logic                 block;

  assign rs1 = if_id.instr[19:15];
  assign rs2 = if_id.instr[24:20];
  assign rd  = if_id.instr[11:7];

  decode_control decode_control_i (
    .instr (if_id.instr),
    .ctrl  (ctrl)
  );

  imm_gen imm_gen_i (
    .instr (if_id.instr),
    .fmt   (ctrl.imm_fmt),
    .imm   (imm)
  );

  hazard_unit hazard_unit_i (
    .rs1    (rs1),
    .rs2    (rs2),
    .ctrl   (ctrl),
    .id_ex  (id_ex),
    .ex_mem (ex_mem),
    .mem_wb (mem_wb),
    .stall  (hz_stall),
    .sel1   (sel1),
    .sel2   (sel2)
  );

  // A flushed slot never waits, otherwise the held wrong-path word would survive
  assign stall = hz_stall && !flush_q;
  assign block = stall || flush_q;

  branch_unit branch_unit_i (
    .if_id         (if_id),
    .ctrl          (ctrl),
    .imm           (imm),
    .sel1          (sel1),
    .sel2          (sel2),
    .ex_mem_result (ex_mem.result),
    .mem_wb_result (mem_wb.result),
    .block         (block),
    .taken         (branch_taken),
    .target        (branch_target)
  );

  //////////////////////////////
  // ID/EX register and flush
  //////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      id_ex.ctrl  <= '0;
      id_ex.valid <= 1'b0;
      flush_q     <= 1'b0;
    end else if (!hold) begin
      flush_q  <= branch_taken;
      id_ex.pc <= if_id.pc;
      if (!stall && !flush_q && if_id.valid) begin
        id_ex.ctrl     <= ctrl;
        id_ex.rs1      <= rs1;
        id_ex.rs2      <= rs2;
        id_ex.rd       <= rd;
        id_ex.rs1_data <= if_id.rs1_data;
        id_ex.rs2_data <= if_id.rs2_data;
        id_ex.imm      <= imm;
        id_ex.valid    <= 1'b1;
      end else begin
        // Bubble
        id_ex.ctrl     <= '0;
        id_ex.rs1      <= '0;
        id_ex.rs2      <= '0;
        id_ex.rd       <= '0;
        id_ex.rs1_data <= '0;
        id_ex.rs2_data <= '0;
        id_ex.imm      <= '0;
        id_ex.valid    <= 1'b0;
      end
    end
  end

  // An empty slot must not write or touch memory downstream
  a_bubble_quiet : assert property (@(posedge bus) disable iff (!rst_n)
    !id_ex.valid |-> !(id_ex.ctrl.reg_write || id_ex.ctrl.mem_read || id_ex.ctrl.mem_write))
    else $error("decode_stage: bubble carries write or memory control");

endmodule

//--- rtl/hazard_unit.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module hazard_unit (
  input  logic [`REG_W-1:0]     rs1,
  input  logic [`REG_W-1:0]     rs2,
  input  decode_pkg::ctrl_t       ctrl,
  input  decode_pkg::id_ex_t      id_ex,
  input  decode_pkg::ex_mem_fwd_t ex_mem,
  input  decode_pkg::mem_wb_fwd_t mem_wb,
  output logic                  stall,
  output decode_pkg::fwd_sel_e    sel1,
  output decode_pkg::fwd_sel_e    sel2
);

  logic rs1_live, rs2_live;
  logic rs1_idex, rs2_idex;
  logic rs1_exmem, rs2_exmem;
  logic resolve;
  logic load_use, br_alu, br_load;

  // Youngest producer wins; a load in EX/MEM has no result yet
  function automatic decode_pkg::fwd_sel_e fwd_pick(input logic [`REG_W-1:0] src,
                                                    input decode_pkg::ex_mem_fwd_t exm,
                                                    input decode_pkg::mem_wb_fwd_t mwb);
    decode_pkg::fwd_sel_e sel;
    sel = decode_pkg::FWD_REG;
    if (src != '0 && exm.reg_write && !exm.mem_read && exm.rd == src) begin
      sel = decode_pkg::FWD_EX_MEM;
    end else if (src != '0 && mwb.reg_write && mwb.rd == src) begin
      sel = decode_pkg::FWD_MEM_WB;
    end
    return sel;
  endfunction

  assign rs1_live  = ctrl.uses_rs1 && (rs1 != '0);
  assign rs2_live  = ctrl.uses_rs2 && (rs2 != '0);
  assign rs1_idex  = rs1_live && (rs1 == id_ex.rd);
  assign rs2_idex  = rs2_live && (rs2 == id_ex.rd);
  assign rs1_exmem = rs1_live && (rs1 == ex_mem.rd);
  assign rs2_exmem = rs2_live && (rs2 == ex_mem.rd);

  // Branches and jalr need their operands in this cycle
  assign resolve  = ctrl.branch || ctrl.jalr;
  assign load_use = (rs1_idex || rs2_idex) && id_ex.ctrl.mem_read;
  assign br_alu   = resolve && (rs1_idex || rs2_idex) && id_ex.ctrl.reg_write;
  assign br_load  = resolve && (rs1_exmem || rs2_exmem) && ex_mem.mem_read;
  assign stall    = load_use || br_alu || br_load;

  assign sel1 = fwd_pick(rs1, ex_mem, mem_wb);
  assign sel2 = fwd_pick(rs2, ex_mem, mem_wb);

  // A stall always traces back to a real destination, never x0
  always_comb begin
    assert (!stall || id_ex.rd != '0 || ex_mem.rd != '0)
      else $error("hazard_unit: stall raised on register zero");
  end

endmodule

//--- rtl/imm_gen.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module imm_gen (
  input  logic [`XLEN-1:0]  instr,
  input  decode_pkg::imm_fmt_e fmt,
  output logic [`XLEN-1:0]  imm
);

  logic sign;

  assign sign = instr[31];

  // Bit scatter per RV32I format, sign from bit 31
  always_comb begin
    case (fmt)
      decode_pkg::IMM_I: imm = {{20{sign}}, instr[31:20]};
      decode_pkg::IMM_S: imm = {{20{sign}}, instr[31:25], instr[11:7]};
      decode_pkg::IMM_B: begin
        imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      decode_pkg::IMM_U: imm = {instr[31:12], 12'h000};
      decode_pkg::IMM_J: begin
        imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: imm = '0;
    endcase
  end

endmodule

//--- testbench/decode_stage_tb.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module decode_stage_tb;

  logic                    bus;
  logic                    rst_n;
  logic                    hold;
  decode_pkg::if_id_t      if_id;
  decode_pkg::ex_mem_fwd_t ex_mem;
  decode_pkg::mem_wb_fwd_t mem_wb;
  decode_pkg::id_ex_t      id_ex;
  logic                    stall;
  logic                    branch_taken;
  logic [`PC_W-1:0]        branch_target;

  // Model state and expected values
  decode_pkg::id_ex_t      exp_reg;
  decode_pkg::id_ex_t      exp_next;
  logic                    exp_flush;
  logic                    exp_stall;
  logic                    exp_taken;
  logic [`PC_W-1:0]        exp_target;
  decode_pkg::ex_mem_fwd_t nx_exm;
  decode_pkg::mem_wb_fwd_t nx_mwb;
  string                   test_name;
  integer                  seed;
  integer                  cycles;

  decode_stage decode_stage_i (
    .bus           (bus),
    .rst_n         (rst_n),
    .hold          (hold),
    .if_id         (if_id),
    .ex_mem        (ex_mem),
    .mem_wb        (mem_wb),
    .id_ex         (id_ex),
    .stall         (stall),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  initial begin
    bus = 1'b0;
    forever #5 bus = ~bus;
  end

  always @(posedge bus) begin
    cycles <= cycles + 1;
    if (cycles >= 1000) begin
      $display("Timeout: the run went past its cycle limit");
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic decode_pkg::ctrl_t ref_ctrl(input logic [31:0] w);
    decode_pkg::ctrl_t   c;
    decode_pkg::alu_op_e op;
    logic lui, auipc, jal, jalr, br, ld, st, opi, opr;
    lui   = (w[6:0] == 7'b0110111);
    auipc = (w[6:0] == 7'b0010111);
    jal   = (w[6:0] == 7'b1101111);
    jalr  = (w[6:0] == 7'b1100111);
    br    = (w[6:0] == 7'b1100011);
    ld    = (w[6:0] == 7'b0000011);
    st    = (w[6:0] == 7'b0100011);
    opi   = (w[6:0] == 7'b0010011);
    opr   = (w[6:0] == 7'b0110011);
    case (w[14:12])
      3'd0: op = (opr && w[30]) ? decode_pkg::SUB : decode_pkg::ADD;
      3'd1: op = decode_pkg::SLL;
      3'd2: op = decode_pkg::SLT;
      3'd3: op = decode_pkg::SLTU;
      3'd4: op = decode_pkg::XOR;
      3'd5: op = w[30] ? decode_pkg::SRA : decode_pkg::SRL;
      3'd6: op = decode_pkg::OR;
      default: op = decode_pkg::AND;
    endcase
    c = '0;
    c.alu_op    = lui ? decode_pkg::PASS_B : ((opi || opr) ? op : decode_pkg::ADD);
    c.alu_src   = lui || auipc || ld || st || opi;
    c.mem_read  = ld;
    c.mem_write = st;
    c.reg_write = lui || auipc || jal || jalr || ld || opi || opr;
    c.mem_size  = (ld || st) ? w[14:12] : 3'd0;
    c.branch    = br;
    c.jal       = jal;
    c.jalr      = jalr;
    c.auipc     = auipc;
    c.lui       = lui;
    c.ecall     = (w == 32'h0000_0073);
    c.uses_rs1  = jalr || br || ld || st || opi || opr;
    c.uses_rs2  = br || st || opr;
    if (lui || auipc) c.imm_fmt = decode_pkg::IMM_U;
    else if (jal) c.imm_fmt = decode_pkg::IMM_J;
    else if (br) c.imm_fmt = decode_pkg::IMM_B;
    else if (st) c.imm_fmt = decode_pkg::IMM_S;
    else if (jalr || ld || opi) c.imm_fmt = decode_pkg::IMM_I;
    return c;
  endfunction

  function automatic logic [31:0] ref_imm(input logic [31:0] w, input decode_pkg::imm_fmt_e f);
    logic [31:0] v;
    case (f)
      decode_pkg::IMM_I: v = 32'($signed(w[31:20]));
      decode_pkg::IMM_S: v = 32'($signed({w[31:25], w[11:7]}));
      decode_pkg::IMM_B: v = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
      decode_pkg::IMM_U: v = {w[31:12], 12'h000};
      decode_pkg::IMM_J: v = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
      default: v = '0;
    endcase
    return v;
  endfunction

  // Youngest writer wins and an EX/MEM load never forwards
  function automatic logic [31:0] operand(input logic [4:0] rs, input logic [31:0] reg_val);
    if (rs != 0 && ex_mem.reg_write && !ex_mem.mem_read && ex_mem.rd == rs) return ex_mem.result;
    if (rs != 0 && mem_wb.reg_write && mem_wb.rd == rs) return mem_wb.result;
    return reg_val;
  endfunction

  task automatic predict();
    decode_pkg::ctrl_t c;
    logic [31:0] im, o1, o2;
    logic [4:0]  rs1, rs2;
    logic        m1, m2, e1, e2, res, cond;
    c   = ref_ctrl(if_id.instr);
    im  = ref_imm(if_id.instr, c.imm_fmt);
    rs1 = if_id.instr[19:15];
    rs2 = if_id.instr[24:20];
    m1  = c.uses_rs1 && rs1 != 0 && rs1 == exp_reg.rd;
    m2  = c.uses_rs2 && rs2 != 0 && rs2 == exp_reg.rd;
    e1  = c.uses_rs1 && rs1 != 0 && rs1 == ex_mem.rd;
    e2  = c.uses_rs2 && rs2 != 0 && rs2 == ex_mem.rd;
    res = c.branch || c.jalr;
    exp_stall = !exp_flush && (((m1 || m2) && exp_reg.ctrl.mem_read) ||
                (res && (m1 || m2) && exp_reg.ctrl.reg_write) ||
                (res && (e1 || e2) && ex_mem.mem_read));
    o1 = operand(rs1, if_id.rs1_data);
    o2 = operand(rs2, if_id.rs2_data);
    case (if_id.instr[14:12])
      3'b000: cond = o1 == o2;
      3'b001: cond = o1 != o2;
      3'b100: cond = $signed(o1) < $signed(o2);
      3'b101: cond = $signed(o1) >= $signed(o2);
      3'b110: cond = o1 < o2;
      3'b111: cond = o1 >= o2;
      default: cond = 1'b0;
    endcase
    exp_taken  = (c.jal || c.jalr || (c.branch && cond)) && !exp_stall && !exp_flush;
    exp_target = c.jalr ? ((o1[15:0] + im[15:0]) & ~16'd1) : (if_id.pc + im[15:0]);
    exp_next   = '0;
    exp_next.pc = if_id.pc;
    if (!exp_stall && !exp_flush && if_id.valid) begin
      exp_next = '{c, rs1, rs2, if_id.instr[11:7], if_id.rs1_data, if_id.rs2_data, im,
                   if_id.pc, 1'b1};
    end
  endtask

  always @(posedge bus) begin
    if (!rst_n) begin
      exp_reg.ctrl  <= '0;
      exp_reg.valid <= 1'b0;
      exp_flush     <= 1'b0;
    end else if (!hold) begin
      exp_reg   <= exp_next;
      exp_flush <= exp_taken;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_reset : assert property (@(negedge bus) !rst_n |-> (id_ex.valid === 1'b0 &&
      id_ex.ctrl.reg_write === 1'b0 && id_ex.ctrl.mem_read === 1'b0 &&
      id_ex.ctrl.mem_write === 1'b0 && branch_taken === 1'b0))
    else begin
      $display("Error %s expected 0 actual valid %b taken %b", test_name, id_ex.valid,
               branch_taken);
      $display("TEST FAILED");
      $fatal(1);
    end

  a_id_ex : assert property (@(negedge bus) disable iff (!rst_n) id_ex === exp_reg)
    else begin
      $display("Error %s expected %h actual %h", test_name, exp_reg, id_ex);
      $display("TEST FAILED");
      $fatal(1);
    end

  a_stall : assert property (@(negedge bus) disable iff (!rst_n) stall === exp_stall)
    else begin
      $display("Error %s expected %b actual %b", test_name, exp_stall, stall);
      $display("TEST FAILED");
      $fatal(1);
    end

  a_taken : assert property (@(negedge bus) disable iff (!rst_n) branch_taken === exp_taken)
    else begin
      $display("Error %s expected %b actual %b", test_name, exp_taken, branch_taken);
      $display("TEST FAILED");
      $fatal(1);
    end

  a_target : assert property (@(negedge bus) disable iff (!rst_n)
      exp_taken |-> branch_target === exp_target)
    else begin
      $display("Error %s expected %h actual %h", test_name, exp_target, branch_target);
      $display("TEST FAILED");
      $fatal(1);
    end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic step(input logic [31:0] w, input logic [31:0] d1, input logic [31:0] d2,
                      input logic [15:0] p, input logic v, input logic h);
    @(posedge bus);
    #1;
    if_id  = '{w, p, d1, d2, v};
    hold   = h;
    ex_mem = nx_exm;
    mem_wb = nx_mwb;
    predict();
  endtask

  // Fetch keeps the word in place while the stage stalls
  task automatic issue(input logic [31:0] w, input logic [31:0] d1, input logic [31:0] d2,
                       input logic [15:0] p);
    step(w, d1, d2, p, 1'b1, 1'b0);
    while (exp_stall) begin
      step(w, d1, d2, p, 1'b1, 1'b0);
    end
  endtask

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] a,
                                        input logic [4:0] b, input logic [12:0] im);
    return {im[12], im[10:5], b, a, f3, im[4:1], im[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] im);
    return {im[20], im[10:1], im[11], im[19:12], rd, 7'b1101111};
  endfunction

  initial begin
    logic [31:0] r, w, a, b, d1, d2;
    logic [15:0] pc;
    logic [2:0]  f3;
    logic [2:0]  btab [6];
    logic        alt;
    integer      k;
    btab = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    seed = 69;
    cycles = 0;
    pc = 16'h0100;
    rst_n = 1'b0;
    hold = 1'b0;
    if_id = '0;
    ex_mem = '0;
    mem_wb = '0;
    nx_exm = '0;
    nx_mwb = '0;
    test_name = "reset";
    predict();
    repeat (16) step(32'h0, 32'h0, 32'h0, pc, 1'b0, 1'b0);
    rst_n = 1'b1;
    step(32'h0, 32'h0, 32'h0, pc, 1'b0, 1'b0);

    test_name = "decode";
    for (int i = 0; i < 200; i++) begin
      k   = {$random(seed)} % 6;
      r   = $random(seed);
      f3  = r[14:12];
      alt = r[30] && (f3 == 3'd0 || f3 == 3'd5);
      case (k)
        0: w = {1'b0, alt, 5'b0, r[24:15], f3, r[11:7], 7'b0110011};
        1: w = {(f3 == 3'd1 || f3 == 3'd5) ? {1'b0, r[30] && f3 == 3'd5, 5'b0} : r[31:25],
                r[24:15], f3, r[11:7], 7'b0010011};
        2: w = {r[31:15], r[14], r[14] ? {1'b0, r[12]} : ((r[13:12] == 2'd3) ? 2'd2 : r[13:12]),
                r[11:7], 7'b0000011};
        3: w = {r[31:15], 1'b0, (r[13:12] == 2'd3) ? 2'd2 : r[13:12], r[11:7], 7'b0100011};
        4: w = {r[31:7], 7'b0110111};
        default: w = {r[31:7], 7'b0010111};
      endcase
      issue(w, $random(seed), $random(seed), pc);
      pc = pc + 16'd4;
    end
    // Illegal, zero and system words
    issue(32'h0000_0000, 32'h1, 32'h2, pc);
    issue(32'hFFFF_FFFF, 32'h1, 32'h2, pc);
    issue(32'h0000_1073, 32'h1, 32'h2, pc);
    issue(32'h0000_0073, 32'h1, 32'h2, pc);

    test_name = "load_use";
    issue(32'h0000_A283, 32'h40, 32'h0, pc);
    issue(32'h0072_8333, 32'h5, 32'h7, pc + 16'd4);
    issue(32'h0000_2003, 32'h40, 32'h0, pc + 16'd8);
    issue(32'h0000_0333, 32'h0, 32'h0, pc + 16'd12);

    test_name = "branch";
    for (int i = 0; i < 12; i++) begin
      a = $random(seed);
      b = (i < 6) ? a : $random(seed);
      d1 = a;
      d2 = b;
      nx_exm = '0;
      nx_mwb = '0;
      if (i % 3 == 1) begin
        nx_exm = '{1'b1, 1'b0, 5'd3, a};
        d1 = ~a;
      end else if (i % 3 == 2) begin
        nx_mwb = '{1'b1, 5'd4, b};
        d2 = ~b;
      end
      issue(enc_b(btab[i % 6], 5'd3, 5'd4, i[0] ? 13'h1FF0 : 13'h0040), d1, d2, pc);
      step(32'h0, 32'h0, 32'h0, pc + 16'd4, 1'b0, 1'b0);
    end
    // Branch operand still in EX
    issue(32'h0020_81B3, 32'h1, 32'h2, pc);
    issue(enc_b(3'b000, 5'd3, 5'd4, 13'h0020), 32'h3, 32'h3, pc + 16'd4);
    step(32'h0, 32'h0, 32'h0, pc + 16'd8, 1'b0, 1'b0);
    nx_exm = '{1'b1, 1'b0, 5'd3, 32'h0000_1235};
    issue({12'h123, 5'd3, 3'b000, 5'd1, 7'b1100111}, 32'h0, 32'h0, pc);
    step(32'h0, 32'h0, 32'h0, pc + 16'd4, 1'b0, 1'b0);
    nx_exm = '0;

    test_name = "flush";
    issue(enc_j(5'd1, 21'h0_0080), 32'h0, 32'h0, pc);
    issue(enc_j(5'd1, 21'h1F_FF00), 32'h0, 32'h0, pc + 16'd4);
    issue(enc_j(5'd2, 21'h0_0010), 32'h0, 32'h0, pc + 16'd8);
    issue(32'h0020_8533, 32'h11, 32'h22, pc + 16'd12);
    step(32'h0, 32'h0, 32'h0, pc, 1'b0, 1'b0);

    test_name = "hold";
    issue(32'h0020_85B3, 32'h5, 32'h6, pc);
    repeat (4) step(32'h4062_8633, 32'h9, 32'h3, pc + 16'd4, 1'b1, 1'b1);
    issue(32'h4062_8633, 32'h9, 32'h3, pc + 16'd4);
    step(32'h0, 32'h0, 32'h0, pc, 1'b0, 1'b0);
    step(32'h0, 32'h0, 32'h0, pc, 1'b0, 1'b0);

    $display("TEST PASSED");
    $finish;
  end

endmodule
